//--- rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int INST_W   = 32;
  localparam int REG_ID_W = 5;
  localparam int OPCODE_W = 7;

  // instruction bit that picks sub and sra
  localparam int ALT_BIT = 30;

  typedef logic [REG_ID_W-1:0] reg_id_t;
  typedef logic [2:0] funct3_t;

  // only the opcodes this core executes
  typedef enum logic [OPCODE_W-1:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } opcode_e;

  // shared by OP and OP-IMM
  typedef enum funct3_t {
    f3_add  = 3'b000,
    f3_sll  = 3'b001,
    f3_slt  = 3'b010,
    f3_sltu = 3'b011,
    f3_xor  = 3'b100,
    f3_sr   = 3'b101,
    f3_or   = 3'b110,
    f3_and  = 3'b111
  } funct3_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

endpackage

//--- cpu_pipe_pkg.sv
package cpu_pipe_pkg;

  localparam int XLEN   = 32;
  localparam int BYTE_W = 8;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [BYTE_W-1:0] byte_t;

  // fetch to decode
  typedef struct packed {
    logic  valid;
    addr_t pc;
    word_t inst;
  } fetch_pkt_t;

  // decode to execute, operands already selected
  typedef struct packed {
    logic                valid;
    rv_isa_pkg::alu_op_e alu_op;
    rv_isa_pkg::reg_id_t rd;
    word_t               a;
    word_t               b;
  } issue_pkt_t;

  // write-back record, also the external retire port
  typedef struct packed {
    logic                valid;
    rv_isa_pkg::reg_id_t rd;
    word_t               value;
  } retire_t;

endpackage

//--- inst_fetcher.sv
`timescale 1ns/1ps

module inst_fetcher #(
  parameter cpu_pipe_pkg::addr_t RESET_PC = '0
) (
  input  logic                     clk_in,
  input  logic                     rst,
  input  logic                     rdy_in,
  input  cpu_pipe_pkg::byte_t      mem_din,
  output cpu_pipe_pkg::addr_t      mem_a,
  output cpu_pipe_pkg::fetch_pkt_t fetch_pkt
);

  typedef enum logic [1:0] {
    fetch_addr,
    fetch_last,
    fetch_done
  } fetch_state_e;

  fetch_state_e        state;
  cpu_pipe_pkg::addr_t pc;
  logic [1:0]          byte_cnt;
  cpu_pipe_pkg::word_t asm_word;

  assign mem_a = pc + cpu_pipe_pkg::addr_t'(byte_cnt);

  always_ff @(posedge clk_in) begin
    if (rst) begin
      state           <= fetch_addr;
      pc              <= RESET_PC;
      byte_cnt        <= '0;
      fetch_pkt.valid <= 1'b0;
    end else if (rdy_in) begin
      fetch_pkt.valid <= 1'b0;
      case (state)
        fetch_addr: begin
          if (byte_cnt == 2'd3) begin
            state <= fetch_last;
          end else begin
            byte_cnt <= byte_cnt + 2'd1;
          end
        end
        fetch_last: begin
          // top byte is on mem_din now
          fetch_pkt.valid <= 1'b1;
          fetch_pkt.pc    <= pc;
          fetch_pkt.inst  <= {mem_din, asm_word[31:8]};
          pc              <= pc + 32'd4;
          byte_cnt        <= '0;
          state           <= fetch_done;
        end
        fetch_done: begin
          // next pc already went out on mem_a this cycle
          byte_cnt <= 2'd1;
          state    <= fetch_addr;
        end
        default: begin
          state <= fetch_addr;
        end
      endcase
    end
  end

  // bytes enter at the top and shift down, so byte 0 ends in [7:0]
  always_ff @(posedge clk_in) begin
    if (rdy_in && state == fetch_addr && byte_cnt != 2'd0) begin
      asm_word <= {mem_din, asm_word[31:8]};
    end
  end

  a_pc_aligned: assert property (
    @(posedge clk_in) disable iff (rst)
    pc[1:0] == 2'b00
  );

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk_in,
  input  logic                  rst,
  input  logic                  rdy_in,
  input  rv_isa_pkg::reg_id_t   rs1,
  input  rv_isa_pkg::reg_id_t   rs2,
  output cpu_pipe_pkg::word_t   rs1_value,
  output cpu_pipe_pkg::word_t   rs2_value,
  input  cpu_pipe_pkg::retire_t retire
);

  // x0 has no storage
  cpu_pipe_pkg::word_t regs [1:31];

  always_ff @(posedge clk_in) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rdy_in && retire.valid && retire.rd != '0) begin
      regs[retire.rd] <= retire.value;
    end
  end

  // no bypass of a same-cycle write
  assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- issuer.sv
`timescale 1ns/1ps

module issuer (
  input  logic                     clk_in,
  input  logic                     rst,
  input  logic                     rdy_in,
  input  cpu_pipe_pkg::fetch_pkt_t fetch_pkt,
  output rv_isa_pkg::reg_id_t      rs1,
  output rv_isa_pkg::reg_id_t      rs2,
  input  cpu_pipe_pkg::word_t      rs1_value,
  input  cpu_pipe_pkg::word_t      rs2_value,
  output cpu_pipe_pkg::issue_pkt_t issue_pkt
);

  logic [rv_isa_pkg::INST_W-1:0] inst;
  rv_isa_pkg::funct3_t           funct3;
  cpu_pipe_pkg::word_t           imm_i;
  cpu_pipe_pkg::word_t           imm_u;
  rv_isa_pkg::alu_op_e           dec_op;
  rv_isa_pkg::reg_id_t           dec_rd;
  cpu_pipe_pkg::word_t           dec_a;
  cpu_pipe_pkg::word_t           dec_b;
  logic                          uses_rs1;
  logic                          uses_rs2;
  logic                          wr_pend_q;
  rv_isa_pkg::reg_id_t           wr_rd_q;

  function automatic rv_isa_pkg::alu_op_e funct_to_op(rv_isa_pkg::funct3_t f3, logic alt);
    case (f3)
      rv_isa_pkg::f3_add:  return alt ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
      rv_isa_pkg::f3_sll:  return rv_isa_pkg::alu_sll;
      rv_isa_pkg::f3_slt:  return rv_isa_pkg::alu_slt;
      rv_isa_pkg::f3_sltu: return rv_isa_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:  return rv_isa_pkg::alu_xor;
      rv_isa_pkg::f3_sr:   return alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
      rv_isa_pkg::f3_or:   return rv_isa_pkg::alu_or;
      default:             return rv_isa_pkg::alu_and;
    endcase
  endfunction

  assign inst   = fetch_pkt.inst;
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_u  = {inst[31:12], 12'b0};

  always_comb begin
    dec_op   = rv_isa_pkg::alu_add;
    dec_rd   = inst[11:7];
    dec_a    = '0;
    dec_b    = '0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (inst[6:0])
      rv_isa_pkg::op_lui: begin
        dec_b = imm_u;
      end
      rv_isa_pkg::op_auipc: begin
        dec_a = fetch_pkt.pc;
        dec_b = imm_u;
      end
      rv_isa_pkg::op_imm: begin
        // bit 30 is immediate data except on the right shifts
        dec_op   = funct_to_op(funct3,
                               funct3 == rv_isa_pkg::f3_sr && inst[rv_isa_pkg::ALT_BIT]);
        dec_a    = rs1_value;
        dec_b    = imm_i;
        uses_rs1 = 1'b1;
      end
      rv_isa_pkg::op_reg: begin
        dec_op   = funct_to_op(funct3, inst[rv_isa_pkg::ALT_BIT]);
        dec_a    = rs1_value;
        dec_b    = rs2_value;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      default: begin
        // retires as a no-op
        dec_rd = '0;
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      issue_pkt.valid <= 1'b0;
      wr_pend_q       <= 1'b0;
    end else if (rdy_in) begin
      issue_pkt.valid <= fetch_pkt.valid;
      if (fetch_pkt.valid) begin
        issue_pkt.alu_op <= dec_op;
        issue_pkt.rd     <= dec_rd;
        issue_pkt.a      <= dec_a;
        issue_pkt.b      <= dec_b;
      end
      // mirrors the write that execute presents next
      wr_pend_q <= issue_pkt.valid && issue_pkt.rd != '0;
      wr_rd_q   <= issue_pkt.rd;
    end
  end

  // operands come straight from the register file, no forwarding path
  a_no_forward: assert property (
    @(posedge clk_in) disable iff (rst)
    rdy_in && fetch_pkt.valid && wr_pend_q |->
      !((uses_rs1 && rs1 == wr_rd_q) || (uses_rs2 && rs2 == wr_rd_q))
  );

endmodule

//--- alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
  input  logic                     clk_in,
  input  logic                     rst,
  input  logic                     rdy_in,
  input  cpu_pipe_pkg::issue_pkt_t issue_pkt,
  output cpu_pipe_pkg::retire_t    retire
);

  cpu_pipe_pkg::word_t op_a;
  cpu_pipe_pkg::word_t op_b;
  cpu_pipe_pkg::word_t result;
  logic [4:0]          shamt;

  assign op_a  = issue_pkt.a;
  assign op_b  = issue_pkt.b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (issue_pkt.alu_op)
      rv_isa_pkg::alu_add:  result = op_a + op_b;
      rv_isa_pkg::alu_sub:  result = op_a - op_b;
      rv_isa_pkg::alu_sll:  result = op_a << shamt;
      rv_isa_pkg::alu_slt:  result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_isa_pkg::alu_sltu: result = {31'b0, op_a < op_b};
      rv_isa_pkg::alu_xor:  result = op_a ^ op_b;
      rv_isa_pkg::alu_srl:  result = op_a >> shamt;
      rv_isa_pkg::alu_sra:  result = cpu_pipe_pkg::word_t'($signed(op_a) >>> shamt);
      rv_isa_pkg::alu_or:   result = op_a | op_b;
      rv_isa_pkg::alu_and:  result = op_a & op_b;
      default:              result = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      retire.valid <= 1'b0;
    end else if (rdy_in) begin
      retire.valid <= issue_pkt.valid;
      if (issue_pkt.valid) begin
        retire.rd    <= issue_pkt.rd;
        // x0 writes are reported as zero
        retire.value <= (issue_pkt.rd == '0) ? '0 : result;
      end
    end
  end

  // fetch spacing keeps retires apart
  a_retire_single: assert property (
    @(posedge clk_in) disable iff (rst)
    retire.valid && rdy_in |=> !retire.valid
  );

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu #(
  parameter cpu_pipe_pkg::addr_t RESET_PC = 32'h0000_0000
) (
  input  logic                  clk_in,
  input  logic                  rst,
  input  logic                  rdy_in,
  input  cpu_pipe_pkg::byte_t   mem_din,
  output cpu_pipe_pkg::addr_t   mem_a,
  output cpu_pipe_pkg::retire_t retire
);

  wire cpu_pipe_pkg::fetch_pkt_t fetch_pkt;
  wire cpu_pipe_pkg::issue_pkt_t issue_pkt;
  wire rv_isa_pkg::reg_id_t      rs1;
  wire rv_isa_pkg::reg_id_t      rs2;
  wire cpu_pipe_pkg::word_t      rs1_value;
  wire cpu_pipe_pkg::word_t      rs2_value;

  inst_fetcher #(
    .RESET_PC (RESET_PC)
  ) i_fetch (
    .clk_in    (clk_in),
    .rst       (rst),
    .rdy_in    (rdy_in),
    .mem_din   (mem_din),
    .mem_a     (mem_a),
    .fetch_pkt (fetch_pkt)
  );

  issuer i_issue (
    .clk_in    (clk_in),
    .rst       (rst),
    .rdy_in    (rdy_in),
    .fetch_pkt (fetch_pkt),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .issue_pkt (issue_pkt)
  );

  // write port fed by the retire record
  reg_file i_regs (
    .clk_in    (clk_in),
    .rst       (rst),
    .rdy_in    (rdy_in),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .retire    (retire)
  );

  alu_stage i_alu (
    .clk_in    (clk_in),
    .rst       (rst),
    .rdy_in    (rdy_in),
    .issue_pkt (issue_pkt),
    .retire    (retire)
  );

endmodule

//--- tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// model register file, x0 is never written
cpu_pipe_pkg::word_t model_regs [0:31];
cpu_pipe_pkg::word_t prog [$];

function automatic cpu_pipe_pkg::word_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic cpu_pipe_pkg::word_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
  return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic cpu_pipe_pkg::word_t u_word(input logic [6:0] opc, input logic [19:0] imm,
                                               input logic [4:0] rd);
  return {imm, rd, opc};
endfunction

// RV32I integer semantics by funct3
function automatic cpu_pipe_pkg::word_t isa_result(input logic [2:0] f3, input logic alt,
                                                   input cpu_pipe_pkg::word_t a,
                                                   input cpu_pipe_pkg::word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic cpu_pipe_pkg::retire_t predict_retire(input cpu_pipe_pkg::word_t inst,
                                                          input cpu_pipe_pkg::addr_t pc);
  cpu_pipe_pkg::retire_t r;
  cpu_pipe_pkg::word_t   imm_i;
  cpu_pipe_pkg::word_t   imm_u;
  imm_i   = {{20{inst[31]}}, inst[31:20]};
  imm_u   = {inst[31:12], 12'h000};
  r.valid = 1'b1;
  r.rd    = inst[11:7];
  r.value = '0;
  case (inst[6:0])
    7'h37: r.value = imm_u;
    7'h17: r.value = pc + imm_u;
    // funct7 only matters for srai among the immediate forms
    7'h13: r.value = isa_result(inst[14:12], inst[30] && inst[14:12] == 3'd5,
                                model_regs[inst[19:15]], imm_i);
    7'h33: r.value = isa_result(inst[14:12], inst[30], model_regs[inst[19:15]],
                                model_regs[inst[24:20]]);
    default: r.rd = '0;
  endcase
  if (r.rd == '0) begin
    r.value = '0;
  end else begin
    model_regs[r.rd] = r.value;
  end
  return r;
endfunction

// lui and auipc, every third a store opcode when asked
task automatic upper_mix(input int n, input bit with_unknown);
  logic [6:0] opc;
  for (int i = 0; i < n; i++) begin
    opc = (i % 2 != 0) ? 7'h17 : 7'h37;
    if (with_unknown && i % 3 == 2) begin
      opc = 7'h23;
    end
    prog.push_back(u_word(opc, 20'($random(seed)), 5'(1 + {$random(seed)} % 31)));
  end
endtask

task automatic imm_chain(input int n);
  logic [4:0]  rd;
  logic [4:0]  src;
  logic [11:0] imm;
  logic [2:0]  f3;
  src = 5'(1 + {$random(seed)} % 31);
  prog.push_back(i_word(12'($random(seed)), 5'd0, 3'd0, src));
  for (int i = 0; i < n; i++) begin
    f3  = 3'(i);
    rd  = 5'(1 + {$random(seed)} % 31);
    imm = 12'($random(seed));
    if (f3 == 3'd1 || f3 == 3'd5) begin
      // shamt form, bit 10 picks srai
      imm[11:5] = {1'b0, f3 == 3'd5 && i[3], 5'b0};
    end else if (f3 == 3'd2 || f3 == 3'd3) begin
      imm[11] = i[3];
    end
    prog.push_back(i_word(imm, src, f3, rd));
    src = rd;
  end
endtask

// small register window so x0 is written and read often
task automatic reg_mix(input int n);
  logic [2:0] f3;
  logic       alt;
  for (int k = 1; k < 8; k++) begin
    prog.push_back(u_word(7'h37, 20'($random(seed)), 5'(k)));
    prog.push_back(i_word(12'($random(seed)), 5'(k), 3'd0, 5'(k)));
  end
  for (int i = 0; i < n; i++) begin
    f3  = 3'($random(seed));
    alt = 1'b0;
    if (i % 4 == 3) begin
      f3  = i[2] ? 3'd5 : 3'd0;
      alt = 1'b1;
    end
    prog.push_back(r_word({1'b0, alt, 5'b0}, 5'({$random(seed)} % 8),
                          5'({$random(seed)} % 8), f3, 5'({$random(seed)} % 8)));
  end
endtask

`endif

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

  localparam cpu_pipe_pkg::addr_t RESET_PC = 32'h0000_0100;
  localparam int RETIRE_TIMEOUT = 50;

  logic                  clk_in;
  logic                  rst;
  logic                  rdy_in;
  cpu_pipe_pkg::byte_t   mem_din;
  cpu_pipe_pkg::addr_t   mem_a;
  cpu_pipe_pkg::retire_t retire;

  int                    seed = 32'hf6d;
  cpu_pipe_pkg::byte_t   ram [0:255];
  cpu_pipe_pkg::addr_t   seen_a;
  logic                  seen_rdy;
  cpu_pipe_pkg::retire_t exp_q [$];
  cpu_pipe_pkg::addr_t   exp_pc;
  string                 cur_test;
  int                    retired;
  int                    active_cyc;
  int                    last_ret_cyc;
  int                    checks;
  int                    errors;
  int                    tests;
  bit                    pause_on;
  int unsigned           stretch_left;

  `include "tb_program.svh"

  cpu #(
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clk_in  (clk_in),
    .rst     (rst),
    .rdy_in  (rdy_in),
    .mem_din (mem_din),
    .mem_a   (mem_a),
    .retire  (retire)
  );

  always #4 clk_in = ~clk_in;

  function automatic cpu_pipe_pkg::byte_t read_byte(input cpu_pipe_pkg::addr_t a);
    // past the program the core reads addi x0, x0, 0
    if (a >= RESET_PC && a < RESET_PC + 32'(4 * prog.size())) begin
      return ram[8'(a - RESET_PC)];
    end
    return 8'(32'h0000_0013 >> {a[1:0], 3'b000});
  endfunction

  // byte RAM, one cycle latency, stalls along with the core
  always @(negedge clk_in) begin
    seen_a   = mem_a;
    seen_rdy = rdy_in;
  end

  always @(posedge clk_in) begin
    #1;
    if (seen_rdy) begin
      mem_din = read_byte(seen_a);
    end
  end

  // random rdy_in stretches, high 1 to 8 cycles, low 1 to 6
  always @(posedge clk_in) begin
    #1;
    if (pause_on) begin
      if (stretch_left == 0) begin
        rdy_in       = ~rdy_in;
        stretch_left = rdy_in ? {$random(seed)} % 8 : {$random(seed)} % 6;
      end else begin
        stretch_left--;
      end
    end
  end

  // only cycles with rdy_in high move the pipeline
  always @(negedge clk_in) begin : retire_check
    cpu_pipe_pkg::retire_t exp;
    if (!rst && rdy_in) begin
      active_cyc++;
      if (i_dut.fetch_pkt.valid) begin
        checks++;
        assert (i_dut.fetch_pkt.pc == exp_pc) else begin
          $display("Fail %s: fetch pc expected %h actual %h", cur_test, exp_pc,
                   i_dut.fetch_pkt.pc);
          errors++;
        end
        exp_pc = exp_pc + 32'd4;
      end
      if (retire.valid) begin
        if (exp_q.size() > 0) begin
          exp = exp_q.pop_front();
        end else begin
          // past the program only the filler no-ops retire
          exp.valid = 1'b1;
          exp.rd    = '0;
          exp.value = '0;
        end
        checks++;
        assert (retire.rd == exp.rd && retire.value == exp.value) else begin
          $display("Fail %s: retire %0d expected x%0d=%h actual x%0d=%h", cur_test, retired,
                   exp.rd, exp.value, retire.rd, retire.value);
          errors++;
        end
        if (last_ret_cyc >= 0) begin
          checks++;
          assert (active_cyc - last_ret_cyc == 5) else begin
            $display("Fail %s: retire spacing expected 5 actual %0d", cur_test,
                     active_cyc - last_ret_cyc);
            errors++;
          end
        end
        last_ret_cyc = active_cyc;
        retired++;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk_in);
    #1;
  endtask

  task automatic reset_dut(input logic rdy_level);
    next_cycle();
    rst    = 1'b1;
    rdy_in = rdy_level;
    exp_q.delete();
    retired      = 0;
    last_ret_cyc = -1;
    exp_pc       = RESET_PC;
    for (int k = 0; k < 32; k++) begin
      model_regs[k] = '0;
    end
    for (int i = 0; i < prog.size(); i++) begin
      exp_q.push_back(predict_retire(prog[i], RESET_PC + 32'(4 * i)));
      for (int b = 0; b < 4; b++) begin
        ram[8'(4 * i + b)] = 8'(prog[i] >> (8 * b));
      end
    end
    repeat (10) next_cycle();
    rst = 1'b0;
  endtask

  task automatic wait_retires(input int n, output bit ok);
    int target;
    int idle;
    ok = 1'b1;
    while (ok && retired < n) begin
      target = retired + 1;
      idle   = 0;
      while (retired < target && idle < RETIRE_TIMEOUT) begin
        @(posedge clk_in);
        idle++;
      end
      if (retired < target) begin
        $display("%s: no retire %0d of %0d within %0d cycles", cur_test, target, n,
                 RETIRE_TIMEOUT);
        errors++;
        ok = 1'b0;
      end
    end
  endtask

  task automatic run_test(input string name, input bit hold_first, input bit with_pause);
    int err_before;
    int chk_before;
    bit ok;
    cur_test   = name;
    err_before = errors;
    chk_before = checks;
    reset_dut(!hold_first);
    if (hold_first) begin
      repeat (20) begin
        @(negedge clk_in);
        checks++;
        assert (mem_a == RESET_PC && !retire.valid) else begin
          $display("Fail %s: idle mem_a expected %h actual %h, retire valid %b", name,
                   RESET_PC, mem_a, retire.valid);
          errors++;
        end
      end
      next_cycle();
      rdy_in = 1'b1;
    end
    pause_on = with_pause;
    wait_retires(prog.size(), ok);
    pause_on = 1'b0;
    next_cycle();
    rdy_in = 1'b1;
    tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - chk_before,
             errors - err_before);
  endtask

  initial begin
    clk_in       = 1'b0;
    rst          = 1'b1;
    rdy_in       = 1'b0;
    mem_din      = '0;
    pause_on     = 1'b0;
    stretch_left = 0;
    active_cyc   = 0;
    checks       = 0;
    errors       = 0;
    tests        = 0;
    prog.delete();
    upper_mix(4, 1'b0);
    run_test("reset_idle", 1'b1, 1'b0);
    prog.delete();
    upper_mix(10, 1'b0);
    run_test("lui_auipc", 1'b0, 1'b0);
    prog.delete();
    imm_chain(24);
    run_test("op_imm_chain", 1'b0, 1'b0);
    prog.delete();
    reg_mix(24);
    run_test("op_reg_mix", 1'b0, 1'b0);
    prog.delete();
    imm_chain(12);
    reg_mix(16);
    run_test("rdy_pauses", 1'b0, 1'b1);
    prog.delete();
    upper_mix(15, 1'b1);
    run_test("spacing_unknown_ops", 1'b0, 1'b0);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
rv_isa_pkg.sv
cpu_pipe_pkg.sv
inst_fetcher.sv
reg_file.sv
issuer.sv
alu_stage.sv
cpu.sv
tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) tb_program.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "run incomplete, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
